// File: design/cavlc_defs.svh
`ifndef CAVLC_DEFS_SVH
`define CAVLC_DEFS_SVH

// frame geometry in 4x4 blocks, width kept a power of two
`define CAVLC_FRAME_W_LOG2  3
`define CAVLC_FRAME_W_BLK   8
`define CAVLC_FRAME_H_BLK   6
`define CAVLC_Y_BITS        3
`define CAVLC_POS_BITS      6     // y and x fields side by side

`define CAVLC_TC_BITS       5     // totalcoeff 0..16
`define CAVLC_NC_BITS       5     // nC up to 16
`define CAVLC_CLASS_BITS    2

// lower nC bound of coeff_token table classes 1, 2 and 3
`define CAVLC_NC_CLASS1     2
`define CAVLC_NC_CLASS2     4
`define CAVLC_NC_CLASS3     8

`endif

// File: design/cavlc_pkg.sv
`include "cavlc_defs.svh"

package cavlc_pkg;

    // y in the upper bits so the raster index carries from x into y
    typedef struct packed {
        logic [`CAVLC_Y_BITS-1:0]       y;
        logic [`CAVLC_FRAME_W_LOG2-1:0] x;
    } blk_xy_t;

    // the same block position seen as one linear count or as coordinates
    typedef union packed {
        logic [`CAVLC_POS_BITS-1:0] idx;   // raster index, incremented
        blk_xy_t                    xy;    // coordinate view
    } blk_pos_u;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,     // nc presented for one cycle
        WAIT_TC,    // hold until totalcoeff arrives
        DONE
    } scan_state_e;

endpackage

// File: design/blk_scan_if.sv
`timescale 1ns/1ns
`include "cavlc_defs.svh"

interface blk_scan_if;

    cavlc_pkg::blk_pos_u              pos;         // current block
    logic                             wen;         // context write strobe
    logic [`CAVLC_TC_BITS-1:0]        totalcoeff;  // decoded value of current block
    logic [`CAVLC_NC_BITS-1:0]        nc;          // predicted nC
    logic [`CAVLC_CLASS_BITS-1:0]     vlc_class;   // coeff_token table class

    modport src (
        output pos
    );

    modport ctrl (
        output wen
    );

    modport ctx (
        input  pos,
        input  wen,
        input  totalcoeff,
        output nc,
        output vlc_class
    );

endinterface

// File: design/blk_pos_counter.sv
`timescale 1ns/1ns
`include "cavlc_defs.svh"

module blk_pos_counter (
    input  logic    clk,
    input  logic    rst,
    input  logic    clear,
    input  logic    advance,
    blk_scan_if.src scan,
    output logic    last
);

    logic x_at_max;
    logic y_at_max;

    // raster walk, x wraps straight into y since width is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            scan.pos.idx <= '0;
        end else if (clear) begin
            scan.pos.idx <= '0;                    // new frame starts at (0,0)
        end else if (advance) begin
            scan.pos.idx <= scan.pos.idx + 1'b1;
        end
    end

    assign x_at_max = (scan.pos.xy.x == `CAVLC_FRAME_W_LOG2'(`CAVLC_FRAME_W_BLK - 1));
    assign y_at_max = (scan.pos.xy.y == `CAVLC_Y_BITS'(`CAVLC_FRAME_H_BLK - 1));

    // bottom right block of the frame
    assign last = x_at_max && y_at_max;

endmodule

// File: design/cavlc_ctx_fsm.sv
`timescale 1ns/1ns

module cavlc_ctx_fsm (
    input  logic     clk,
    input  logic     rst,
    input  logic     frame_start,
    input  logic     tc_valid,
    input  logic     last,
    output logic     clear,
    output logic     advance,
    output logic     nc_valid,
    output logic     frame_done,
    output logic     busy,
    blk_scan_if.ctrl scan
);

    cavlc_pkg::scan_state_e state;
    cavlc_pkg::scan_state_e state_nxt;
    logic                   tc_accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cavlc_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // totalcoeff only counts while waiting for it
    assign tc_accept = (state == cavlc_pkg::WAIT_TC) && tc_valid;

    always_comb begin
        state_nxt = state;
        case (state)
            cavlc_pkg::IDLE: begin
                if (frame_start) begin
                    state_nxt = cavlc_pkg::LOOKUP;
                end
            end
            cavlc_pkg::LOOKUP: begin
                state_nxt = cavlc_pkg::WAIT_TC;    // nc shown for one cycle only
            end
            cavlc_pkg::WAIT_TC: begin
                if (tc_valid) begin
                    state_nxt = last ? cavlc_pkg::DONE : cavlc_pkg::LOOKUP;
                end
            end
            cavlc_pkg::DONE: begin
                state_nxt = cavlc_pkg::IDLE;
            end
            default: begin
                state_nxt = cavlc_pkg::IDLE;
            end
        endcase
    end

    assign clear    = (state == cavlc_pkg::IDLE) && frame_start;  // rewind position
    assign scan.wen = tc_accept;                                   // store context now
    assign advance  = tc_accept && !last;     // position holds on the final block

    // strobes straight from the state
    assign nc_valid   = (state == cavlc_pkg::LOOKUP);
    assign frame_done = (state == cavlc_pkg::DONE);
    assign busy       = (state == cavlc_pkg::LOOKUP) || (state == cavlc_pkg::WAIT_TC);

endmodule

// File: design/nc_compute.sv
`timescale 1ns/1ns
`include "cavlc_defs.svh"

module nc_compute (
    input  logic    clk,
    input  logic    rst,
    blk_scan_if.ctx scan
);

    logic [`CAVLC_TC_BITS-1:0]       left_tc [`CAVLC_FRAME_H_BLK];  // one per row
    logic [`CAVLC_TC_BITS-1:0]       top_tc  [`CAVLC_FRAME_W_BLK];  // one per column
    logic [`CAVLC_FRAME_W_LOG2-1:0]  blk_x;
    logic [`CAVLC_Y_BITS-1:0]        blk_y;
    logic                            left_avail;
    logic                            top_avail;
    logic [`CAVLC_TC_BITS-1:0]       n_a;
    logic [`CAVLC_TC_BITS-1:0]       n_b;
    logic [`CAVLC_TC_BITS:0]         n_sum;     // one extra bit for a + b + 1

    assign blk_x = scan.pos.xy.x;
    assign blk_y = scan.pos.xy.y;

    // no slices here, so a neighbour exists whenever the coordinate is non-zero
    assign left_avail = (blk_x != '0);
    assign top_avail  = (blk_y != '0);

    // the entry for a row is the block just left of the current one,
    // the entry for a column is the block just above it
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CAVLC_FRAME_H_BLK; i++) begin
                left_tc[i] <= '0;
            end
            for (int j = 0; j < `CAVLC_FRAME_W_BLK; j++) begin
                top_tc[j] <= '0;
            end
        end else if (scan.wen) begin
            left_tc[blk_y] <= scan.totalcoeff;
            top_tc[blk_x]  <= scan.totalcoeff;
        end
    end

    assign n_a   = left_tc[blk_y];
    assign n_b   = top_tc[blk_x];
    assign n_sum = {1'b0, n_a} + {1'b0, n_b} + 1'b1;

    always_comb begin
        if (!left_avail && !top_avail) begin
            scan.nc = '0;                            // corner block
        end else if (left_avail && !top_avail) begin
            scan.nc = n_a;                           // top row
        end else if (!left_avail && top_avail) begin
            scan.nc = n_b;                           // left column
        end else begin
            scan.nc = n_sum[`CAVLC_TC_BITS:1];       // rounded average
        end
    end

    // coeff_token table class from nC
    always_comb begin
        if (scan.nc >= `CAVLC_NC_BITS'(`CAVLC_NC_CLASS3)) begin
            scan.vlc_class = 2'd3;
        end else if (scan.nc >= `CAVLC_NC_BITS'(`CAVLC_NC_CLASS2)) begin
            scan.vlc_class = 2'd2;
        end else if (scan.nc >= `CAVLC_NC_BITS'(`CAVLC_NC_CLASS1)) begin
            scan.vlc_class = 2'd1;
        end else begin
            scan.vlc_class = 2'd0;
        end
    end

endmodule

// File: design/cavlc_ctx_top.sv
`timescale 1ns/1ns
`include "cavlc_defs.svh"

module cavlc_ctx_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              frame_start,
    input  logic                              tc_valid,
    input  logic [`CAVLC_TC_BITS-1:0]         totalcoeff,
    output logic                              nc_valid,
    output logic [`CAVLC_NC_BITS-1:0]         nc,
    output logic [`CAVLC_CLASS_BITS-1:0]      vlc_class,
    output logic [`CAVLC_FRAME_W_LOG2-1:0]    block_x,
    output logic [`CAVLC_Y_BITS-1:0]          block_y,
    output logic                              frame_done,
    output logic                              busy
);

    logic clear;
    logic advance;
    logic last;

    blk_scan_if scan ();

    assign scan.totalcoeff = totalcoeff;

    blk_pos_counter blk_pos_counter_i (
        .clk     (clk),
        .rst     (rst),
        .clear   (clear),
        .advance (advance),
        .scan    (scan.src),
        .last    (last)
    );

    cavlc_ctx_fsm cavlc_ctx_fsm_i (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .tc_valid    (tc_valid),
        .last        (last),
        .clear       (clear),
        .advance     (advance),
        .nc_valid    (nc_valid),
        .frame_done  (frame_done),
        .busy        (busy),
        .scan        (scan.ctrl)
    );

    nc_compute nc_compute_i (
        .clk  (clk),
        .rst  (rst),
        .scan (scan.ctx)
    );

    assign nc        = scan.nc;
    assign vlc_class = scan.vlc_class;
    assign block_x   = scan.pos.xy.x;   // coordinate view of the position
    assign block_y   = scan.pos.xy.y;

endmodule

// File: dv/cavlc_ctx_tb.sv
`timescale 1ns/1ns
`include "cavlc_defs.svh"

module cavlc_ctx_tb;

    localparam int          CLK_PERIOD       = 40;
    localparam int          DRIVE_DELAY      = 2;      // after the rising edge
    localparam int          RESET_CYCLES     = 3;
    localparam int unsigned SEED             = 32'haaff50c1;
    localparam int          NUM_FRAMES       = 3;
    localparam int          FRAME_BLOCKS     = `CAVLC_FRAME_W_BLK * `CAVLC_FRAME_H_BLK;
    localparam int          MAX_WAIT         = 5;
    localparam int          CYCLES_PER_BLOCK = 9;      // lookup, wait, accept, with slack
    localparam int          TIMEOUT_CYCLES   = NUM_FRAMES * FRAME_BLOCKS * CYCLES_PER_BLOCK + 700;

    logic                            clk;
    logic                            rst;
    logic                            frame_start;
    logic                            tc_valid;
    logic [`CAVLC_TC_BITS-1:0]       totalcoeff;
    logic                            nc_valid;
    logic [`CAVLC_NC_BITS-1:0]       nc;
    logic [`CAVLC_CLASS_BITS-1:0]    vlc_class;
    logic [`CAVLC_FRAME_W_LOG2-1:0]  block_x;
    logic [`CAVLC_Y_BITS-1:0]        block_y;
    logic                            frame_done;
    logic                            busy;

    int          left_model [`CAVLC_FRAME_H_BLK];   // last totalcoeff per row
    int          top_model  [`CAVLC_FRAME_W_BLK];   // last totalcoeff per column
    int          model_x;
    int          model_y;
    int          error_count;
    int          check_count;
    int          cycle_count;

    cavlc_ctx_top cavlc_ctx_top_i (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .tc_valid    (tc_valid),
        .totalcoeff  (totalcoeff),
        .nc_valid    (nc_valid),
        .nc          (nc),
        .vlc_class   (vlc_class),
        .block_x     (block_x),
        .block_y     (block_y),
        .frame_done  (frame_done),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hard stop in case the DUT never finishes a frame
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles before all frames completed", cycle_count);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // outputs come from registers only, so they are settled by the drive point
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    function automatic int predict_nc(input int x, input int y);
        if (x == 0 && y == 0) begin
            return 0;
        end
        if (y == 0) begin
            return left_model[y];
        end
        if (x == 0) begin
            return top_model[x];
        end
        return (left_model[y] + top_model[x] + 1) / 2;   // rounded down
    endfunction

    function automatic int class_of_nc(input int n);
        if (n < `CAVLC_NC_CLASS1) begin
            return 0;
        end else if (n < `CAVLC_NC_CLASS2) begin
            return 1;
        end else if (n < `CAVLC_NC_CLASS3) begin
            return 2;
        end
        return 3;
    endfunction

    task automatic check_idle();
        check_value("nc_valid", 0, int'(nc_valid));
        check_value("frame_done", 0, int'(frame_done));
        check_value("busy", 0, int'(busy));
    endtask

    task automatic check_position();
        check_value("block_x", model_x, int'(block_x));
        check_value("block_y", model_y, int'(block_y));
    endtask

    // nc follows the held position and the storage even while idle
    task automatic check_held_context();
        check_position();
        check_value("nc", predict_nc(model_x, model_y), int'(nc));
    endtask

    // IDLE cycles with stray tc_valid pulses that must not touch the context
    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            check_idle();
            check_held_context();
            tc_valid   = ($urandom_range(1, 0) == 1);
            totalcoeff = `CAVLC_TC_BITS'($urandom_range(16, 1));
            next_cycle();
            tc_valid   = 1'b0;
        end
        check_idle();
        check_held_context();
    endtask

    task automatic run_frame();
        int wait_cycles;
        int tc;
        frame_start = 1'b1;
        next_cycle();
        frame_start = 1'b0;
        model_x = 0;
        model_y = 0;
        for (int b = 0; b < FRAME_BLOCKS; b++) begin
            check_value("nc_valid", 1, int'(nc_valid));
            check_value("busy", 1, int'(busy));
            check_position();
            check_value("nc", predict_nc(model_x, model_y), int'(nc));
            check_value("vlc_class", class_of_nc(predict_nc(model_x, model_y)), int'(vlc_class));
            tc_valid    = ($urandom_range(3, 0) == 0);   // too early, dropped
            totalcoeff  = `CAVLC_TC_BITS'($urandom_range(16, 0));
            frame_start = ($urandom_range(3, 0) == 0);   // no restart while busy
            next_cycle();
            tc_valid    = 1'b0;
            frame_start = 1'b0;
            wait_cycles = $urandom_range(MAX_WAIT, 0);
            repeat (wait_cycles) begin
                check_value("nc_valid", 0, int'(nc_valid));
                check_value("busy", 1, int'(busy));
                check_position();
                frame_start = ($urandom_range(3, 0) == 0);
                next_cycle();
                frame_start = 1'b0;
            end
            check_value("nc_valid", 0, int'(nc_valid));
            check_position();
            tc         = $urandom_range(16, 0);
            tc_valid   = 1'b1;
            totalcoeff = `CAVLC_TC_BITS'(tc);
            next_cycle();
            tc_valid   = 1'b0;
            left_model[model_y] = tc;
            top_model[model_x]  = tc;
            if (model_x == `CAVLC_FRAME_W_BLK - 1) begin
                if (model_y != `CAVLC_FRAME_H_BLK - 1) begin
                    model_x = 0;
                    model_y++;
                end
            end else begin
                model_x++;
            end
        end
        check_value("frame_done", 1, int'(frame_done));
        check_value("busy", 0, int'(busy));
        check_value("nc_valid", 0, int'(nc_valid));
        next_cycle();
        check_value("frame_done", 0, int'(frame_done));   // one cycle only
    endtask

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        frame_start = 1'b0;
        tc_valid    = 1'b0;
        totalcoeff  = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        model_x     = 0;
        model_y     = 0;
        for (int i = 0; i < `CAVLC_FRAME_H_BLK; i++) begin
            left_model[i] = 0;
        end
        for (int j = 0; j < `CAVLC_FRAME_W_BLK; j++) begin
            top_model[j] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        check_idle();
        check_position();
        idle_gap(3);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame();
            idle_gap($urandom_range(3, 1));
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+design
design/cavlc_pkg.sv
design/blk_scan_if.sv
design/blk_pos_counter.sv
design/cavlc_ctx_fsm.sv
design/nc_compute.sv
design/cavlc_ctx_top.sv
dv/cavlc_ctx_tb.sv

// File: Makefile
# Verilator build and run of the CAVLC neighbour context testbench

VERILATOR ?= verilator
TOP       ?= cavlc_ctx_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
